/* bench/hisBuilderTb.sv */
`timescale 1ns/10ps
`include "hisBuilder_params.svh"

module hisBuilderTb
    import hisBuilderPkg::*;
();

    localparam int BINS          = 1 << `HB_BIN_WIDTH;
    localparam int FRAMES        = 3;
    localparam int FRAME_SAMPLES = `HB_DATA_NUM * `HB_PIXEL_NUM * `HB_ACQ_NUM;
    // five cycles of 10 ns per sample is ample room for the gaps
    localparam int TIMEOUT_NS    = FRAMES * FRAME_SAMPLES * 5 * 10;

    logic      clk;
    logic      combin_res;
    logic      wrEn;
    binAddr_t  addr;
    logic      countValid;
    binCount_t binCount;
    pixelIdx_t countPixel;
    logic      peakDone;
    binAddr_t  peakBins [`HB_PIXEL_NUM];
    logic      hisNum;

    // reference model state
    int       refHits [`HB_PIXEL_NUM][BINS];
    int       refMax [`HB_PIXEL_NUM];
    binAddr_t refMaxBin [`HB_PIXEL_NUM];
    int       refSample;
    int       refPix;
    int       refAcq;
    int       lastPixel;
    bit       lastOfFrame;
    binAddr_t framePeaks [`HB_PIXEL_NUM];

    // expected results, in DUT order
    binCount_t expCountQ [$];
    pixelIdx_t expPixelQ [$];
    int        validDueQ [$];
    int        doneDueQ [$];
    binAddr_t  expPeakQ [$];

    // what the outputs should show right now
    binAddr_t pubPeaks [`HB_PIXEL_NUM];
    logic     refHis;
    int       donePulses;
    int       cycleCnt;
    // favourite bin per pixel, skews each frame
    binAddr_t favBin [`HB_PIXEL_NUM];

    hisBuilderTop dut_i (
        .clk        (clk),
        .combin_res (combin_res),
        .wrEn       (wrEn),
        .addr       (addr),
        .countValid (countValid),
        .binCount   (binCount),
        .countPixel (countPixel),
        .peakDone   (peakDone),
        .peakBins   (peakBins),
        .hisNum     (hisNum)
    );

    always #5 clk = ~clk;

    // rising edges since time zero
    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
    end

    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic checkCount(input string name, input binCount_t expVal, input binCount_t actVal);
        if (actVal !== expVal) begin
            stopOnError($sformatf("Mismatch at %0t: %s expected %0d, got %0d",
                $time, name, expVal, actVal));
        end
    endtask

    task automatic checkBin(input string name, input binAddr_t expVal, input binAddr_t actVal);
        if (actVal !== expVal) begin
            stopOnError($sformatf("Mismatch at %0t: %s expected 0x%0h, got 0x%0h",
                $time, name, expVal, actVal));
        end
    endtask

    task automatic checkFlag(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            stopOnError($sformatf("Mismatch at %0t: %s expected %b, got %b",
                $time, name, expVal, actVal));
        end
    endtask

    function automatic void clearReference();
        for (int p = 0; p < `HB_PIXEL_NUM; p++) begin
            for (int b = 0; b < BINS; b++) begin
                refHits[p][b] = 0;
            end
            refMax[p]    = 0;
            refMaxBin[p] = '0;
        end
    endfunction

    // count of the sample's bin after this hit
    // also tracks position in the frame and the running peaks
    function automatic binCount_t predictCount(input binAddr_t bin);
        int hits;
        hits = refHits[refPix][bin] + 1;
        refHits[refPix][bin] = hits;
        // strictly greater, earlier bin keeps a tie
        if (hits > refMax[refPix]) begin
            refMax[refPix]    = hits;
            refMaxBin[refPix] = bin;
        end
        lastPixel   = refPix;
        lastOfFrame = 1'b0;
        refSample++;
        if (refSample == `HB_DATA_NUM) begin
            refSample = 0;
            refPix++;
            if (refPix == `HB_PIXEL_NUM) begin
                refPix = 0;
                refAcq++;
                if (refAcq == `HB_ACQ_NUM) begin
                    refAcq      = 0;
                    lastOfFrame = 1'b1;
                end
            end
        end
        if (lastOfFrame) begin
            framePeaks = refMaxBin;
            clearReference();
        end
        return binCount_t'(hits);
    endfunction

    // half the hits go to the pixel's favourite bin
    function automatic binAddr_t pickBin(input int pix);
        if ($urandom_range(0, 1) == 0) begin
            return favBin[pix];
        end
        return binAddr_t'($urandom_range(0, BINS - 1));
    endfunction

    // compare on the falling edge, outputs settled
    always @(negedge clk) begin
        logic expectValid;
        logic expectDone;
        expectValid = (validDueQ.size() > 0) && (validDueQ[0] == cycleCnt);
        expectDone  = (doneDueQ.size() > 0) && (doneDueQ[0] == cycleCnt);
        checkFlag("countValid", expectValid, countValid);
        if (expectValid) begin
            void'(validDueQ.pop_front());
            checkCount("binCount", expCountQ.pop_front(), binCount);
            checkBin("countPixel", binAddr_t'(expPixelQ.pop_front()), binAddr_t'(countPixel));
        end
        // pulses seen on the DUT output
        if (peakDone === 1'b1) begin
            donePulses++;
        end
        checkFlag("peakDone", expectDone, peakDone);
        if (expectDone) begin
            void'(doneDueQ.pop_front());
            for (int p = 0; p < `HB_PIXEL_NUM; p++) begin
                pubPeaks[p] = expPeakQ.pop_front();
            end
            refHis = ~refHis;
        end
        // parity and peaks hold between frame ends
        checkFlag("hisNum", refHis, hisNum);
        for (int p = 0; p < `HB_PIXEL_NUM; p++) begin
            checkBin($sformatf("peakBins[%0d]", p), pubPeaks[p], peakBins[p]);
        end
    end

    initial begin
        #(TIMEOUT_NS);
        stopOnError("Timeout: the run did not finish in the expected time");
    end

    initial begin
        int        gap;
        binCount_t cnt;
        binAddr_t  bin;
        void'($urandom(48440));
        clk        = 1'b0;
        combin_res = 1'b0;
        wrEn       = 1'b0;
        addr       = '0;
        cycleCnt   = 0;
        refSample  = 0;
        refPix     = 0;
        refAcq     = 0;
        refHis     = 1'b0;
        donePulses = 0;
        clearReference();
        for (int p = 0; p < `HB_PIXEL_NUM; p++) begin
            pubPeaks[p] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        combin_res = 1'b1;
        for (int f = 0; f < FRAMES; f++) begin
            for (int p = 0; p < `HB_PIXEL_NUM; p++) begin
                favBin[p] = binAddr_t'($urandom_range(0, BINS - 1));
            end
            for (int s = 0; s < FRAME_SAMPLES; s++) begin
                @(posedge clk);
                #1;
                bin  = pickBin(refPix);
                wrEn = 1'b1;
                addr = bin;
                cnt  = predictCount(bin);
                expCountQ.push_back(cnt);
                expPixelQ.push_back(pixelIdx_t'(lastPixel));
                // accepted at the next edge, count one edge after that
                validDueQ.push_back(cycleCnt + 2);
                if (lastOfFrame) begin
                    doneDueQ.push_back(cycleCnt + 3);
                    for (int p = 0; p < `HB_PIXEL_NUM; p++) begin
                        expPeakQ.push_back(framePeaks[p]);
                    end
                end
                // first frame runs back to back
                gap = (f == 0) ? 0 : int'($urandom_range(0, 3));
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                    wrEn = 1'b0;
                end
            end
        end
        @(posedge clk);
        #1;
        wrEn = 1'b0;
        while ((validDueQ.size() > 0) || (doneDueQ.size() > 0)) begin
            @(posedge clk);
        end
        // idle tail, any stray peakDone shows up here
        repeat (5) @(posedge clk);
        if (donePulses != FRAMES) begin
            stopOnError($sformatf("saw %0d frame ends instead of %0d", donePulses, FRAMES));
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

/* include/hisBuilder_params.svh */
`ifndef HISBUILDER_PARAMS_SVH
`define HISBUILDER_PARAMS_SVH

// width of one bin address
// 4 bits give 16 bins per pixel
`define HB_BIN_WIDTH 4

// width of one bin count
`define HB_COUNT_WIDTH 8

// pixels in one acquisition
`define HB_PIXEL_NUM 4

// samples per pixel in one acquisition
`define HB_DATA_NUM 8

// acquisitions in one frame
`define HB_ACQ_NUM 3

// depth of the count memory, all bins of all pixels
`define HB_BINS_TOTAL (`HB_PIXEL_NUM * (1 << `HB_BIN_WIDTH))

`endif

/* run_sim.sh */
#!/bin/sh
# compile and run the histogram builder testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --Mdir "$BUILD" -o simv \
    --top-module hisBuilderTb \
    -f vlog.f
if [ $? -ne 0 ]; then
    echo "build step failed"
    exit 1
fi

"./$BUILD/simv" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "simulator exited with status $simStatus"
    exit 1
fi
exit 0

/* src/hisBuilderPkg.sv */
`include "hisBuilder_params.svh"

package hisBuilderPkg;

    // bits needed to number the pixels
    // at least one bit even for a single pixel
    localparam int PIXEL_IDX_WIDTH = (`HB_PIXEL_NUM > 1) ? $clog2(`HB_PIXEL_NUM) : 1;

    // bin address of one sample
    typedef logic [`HB_BIN_WIDTH-1:0] binAddr_t;

    // hits collected in one bin
    typedef logic [`HB_COUNT_WIDTH-1:0] binCount_t;

    // pixel number inside an acquisition
    typedef logic [PIXEL_IDX_WIDTH-1:0] pixelIdx_t;

endpackage

/* src/hisBuilderTop.sv */
`timescale 1ns/10ps
`include "hisBuilder_params.svh"

module hisBuilderTop
    import hisBuilderPkg::*;
(
    input  logic      clk,
    input  logic      combin_res,
    input  logic      wrEn,
    input  binAddr_t  addr,
    output logic      countValid,
    output binCount_t binCount,
    output pixelIdx_t countPixel,
    output logic      peakDone,
    output binAddr_t  peakBins [`HB_PIXEL_NUM],
    output logic      hisNum
);

    // sequencer to memory
    logic      wrStrobe;
    binAddr_t  wrBin;
    pixelIdx_t wrPixel;
    logic      wrLast;

    // memory to peak tracker
    // countValid, binCount and countPixel also leave the top
    binAddr_t  countBin;
    logic      countLast;

    // tags every sample with pixel and frame end
    sampleSequencer sequencer_i (
        .clk        (clk),
        .combin_res (combin_res),
        .wrEn       (wrEn),
        .addr       (addr),
        .wrStrobe   (wrStrobe),
        .wrBin      (wrBin),
        .wrPixel    (wrPixel),
        .wrLast     (wrLast)
    );

    // counts hits per bin
    histogramRam histRam_i (
        .clk        (clk),
        .combin_res (combin_res),
        .wrStrobe   (wrStrobe),
        .wrBin      (wrBin),
        .wrPixel    (wrPixel),
        .wrLast     (wrLast),
        .countValid (countValid),
        .binCount   (binCount),
        .countBin   (countBin),
        .countPixel (countPixel),
        .countLast  (countLast)
    );

    // per-pixel peaks, published once per frame
    peakTracker peak_i (
        .clk        (clk),
        .combin_res (combin_res),
        .countValid (countValid),
        .binCount   (binCount),
        .countBin   (countBin),
        .countPixel (countPixel),
        .countLast  (countLast),
        .peakBins   (peakBins),
        .peakDone   (peakDone),
        .hisNum     (hisNum)
    );

endmodule

/* src/histogramRam.sv */
`timescale 1ns/10ps
`include "hisBuilder_params.svh"

module histogramRam
    import hisBuilderPkg::*;
(
    input  logic      clk,
    input  logic      combin_res,
    input  logic      wrStrobe,
    input  binAddr_t  wrBin,
    input  pixelIdx_t wrPixel,
    input  logic      wrLast,
    output logic      countValid,
    output binCount_t binCount,
    output binAddr_t  countBin,
    output pixelIdx_t countPixel,
    output logic      countLast
);

    // memory index is pixel then bin
    localparam int IDX_W = PIXEL_IDX_WIDTH + `HB_BIN_WIDTH;

    // one count per bin of every pixel
    binCount_t countMem [`HB_BINS_TOTAL];
    // a clear bit means the stored count is stale
    logic [`HB_BINS_TOTAL-1:0] binValid;

    logic [IDX_W-1:0] memIdx;
    binCount_t        storedCount;
    binCount_t        newCount;

    // pixel * bins per pixel + bin
    // stays below the memory depth for any pixel number
    assign memIdx = {wrPixel, wrBin};

    // read side of the read-modify-write
    assign storedCount = countMem[memIdx];

    // first hit in a frame starts at 1
    assign newCount = binValid[memIdx] ? binCount_t'(storedCount + 1'b1) : binCount_t'(1);

    // write back in the same cycle
    // a repeated bin next cycle already sees this value
    always_ff @(posedge clk) begin
        if (wrStrobe) begin
            countMem[memIdx] <= newCount;
        end
    end

    // valid bits per bin
    // frame end wipes them all, including the bin written now
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid <= '0;
        end else if (wrStrobe && wrLast) begin
            binValid <= '0;
        end else if (wrStrobe) begin
            binValid[memIdx] <= 1'b1;
        end
    end

    // result strobes
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            countValid <= 1'b0;
            countLast  <= 1'b0;
        end else begin
            countValid <= wrStrobe;
            countLast  <= wrStrobe && wrLast;
        end
    end

    // updated count with its bin and pixel
    always_ff @(posedge clk) begin
        if (wrStrobe) begin
            binCount   <= newCount;
            countBin   <= wrBin;
            countPixel <= wrPixel;
        end
    end

    // a live bin must not wrap to zero
    countOverflowChk: assert property (
        @(posedge clk) disable iff (!combin_res)
        (wrStrobe && binValid[memIdx]) |-> (storedCount != '1)
    ) else $error("bin count overflow");

endmodule

/* src/peakTracker.sv */
`timescale 1ns/10ps
`include "hisBuilder_params.svh"

module peakTracker
    import hisBuilderPkg::*;
(
    input  logic      clk,
    input  logic      combin_res,
    input  logic      countValid,
    input  binCount_t binCount,
    input  binAddr_t  countBin,
    input  pixelIdx_t countPixel,
    input  logic      countLast,
    output binAddr_t  peakBins [`HB_PIXEL_NUM],
    output logic      peakDone,
    output logic      hisNum
);

    // running maximum per pixel
    binCount_t maxCount [`HB_PIXEL_NUM];
    // bin that first reached that maximum
    binAddr_t  maxBin [`HB_PIXEL_NUM];

    logic newMax;
    logic frameEnd;

    // strictly greater only
    // so on a tie the earlier bin stays
    assign newMax   = countValid && (binCount > maxCount[countPixel]);
    assign frameEnd = countValid && countLast;

    // maxima, published peaks, frame parity
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < `HB_PIXEL_NUM; p++) begin
                maxCount[p] <= '0;
                peakBins[p] <= '0;
            end
            peakDone <= 1'b0;
            hisNum   <= 1'b0;
        end else begin
            peakDone <= frameEnd;
            if (frameEnd) begin
                hisNum <= ~hisNum;
                for (int p = 0; p < `HB_PIXEL_NUM; p++) begin
                    // last sample may still move its own pixel's peak
                    if (newMax && (countPixel == pixelIdx_t'(p))) begin
                        peakBins[p] <= countBin;
                    end else begin
                        peakBins[p] <= maxBin[p];
                    end
                    // next frame starts from zero
                    maxCount[p] <= '0;
                end
            end else if (newMax) begin
                maxCount[countPixel] <= binCount;
            end
        end
    end

    // peak bin follows its count
    // a cleared maximum lets the next hit overwrite it
    always_ff @(posedge clk) begin
        if (newMax) begin
            maxBin[countPixel] <= countBin;
        end
    end

    // one pulse per frame, never stretched
    peakDonePulseChk: assert property (
        @(posedge clk) disable iff (!combin_res)
        peakDone |=> !peakDone
    ) else $error("peakDone high on two consecutive cycles");

endmodule

/* src/sampleSequencer.sv */
`timescale 1ns/10ps
`include "hisBuilder_params.svh"

module sampleSequencer
    import hisBuilderPkg::*;
(
    input  logic      clk,
    input  logic      combin_res,
    input  logic      wrEn,
    input  binAddr_t  addr,
    output logic      wrStrobe,
    output binAddr_t  wrBin,
    output pixelIdx_t wrPixel,
    output logic      wrLast
);

    // counter widths, never below one bit
    localparam int SAMPLE_W = (`HB_DATA_NUM > 1) ? $clog2(`HB_DATA_NUM) : 1;
    localparam int ACQ_W    = (`HB_ACQ_NUM > 1) ? $clog2(`HB_ACQ_NUM) : 1;

    // nested position counters
    logic [SAMPLE_W-1:0] sampleCnt;
    pixelIdx_t           pixelCnt;
    logic [ACQ_W-1:0]    acqCnt;

    // terminal count flags
    logic sampleLast;
    logic pixelLast;
    logic acqLast;
    logic frameLast;

    assign sampleLast = (sampleCnt == SAMPLE_W'(`HB_DATA_NUM - 1));
    assign pixelLast  = (pixelCnt == PIXEL_IDX_WIDTH'(`HB_PIXEL_NUM - 1));
    assign acqLast    = (acqCnt == ACQ_W'(`HB_ACQ_NUM - 1));
    // current sample closes the frame
    assign frameLast  = sampleLast && pixelLast && acqLast;

    // sample -> pixel -> acquisition
    // each level advances only when the one below wraps
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixelCnt  <= '0;
            acqCnt    <= '0;
        end else if (wrEn) begin
            if (sampleLast) begin
                sampleCnt <= '0;
                if (pixelLast) begin
                    pixelCnt <= '0;
                    // wrap of the acquisition count ends the frame
                    if (acqLast) begin
                        acqCnt <= '0;
                    end else begin
                        acqCnt <= acqCnt + 1'b1;
                    end
                end else begin
                    pixelCnt <= pixelCnt + 1'b1;
                end
            end else begin
                sampleCnt <= sampleCnt + 1'b1;
            end
        end
    end

    // strobe and frame marker
    // wrLast only ever rides along with a strobe
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            wrStrobe <= 1'b0;
            wrLast   <= 1'b0;
        end else begin
            wrStrobe <= wrEn;
            wrLast   <= wrEn && frameLast;
        end
    end

    // sample payload tagged with its pixel
    always_ff @(posedge clk) begin
        if (wrEn) begin
            wrBin   <= addr;
            wrPixel <= pixelCnt;
        end
    end

    // counters never reach their limits
    counterRangeChk: assert property (
        @(posedge clk) disable iff (!combin_res)
        (sampleCnt < `HB_DATA_NUM) && (pixelCnt < `HB_PIXEL_NUM) && (acqCnt < `HB_ACQ_NUM)
    ) else $error("sequencer counter out of range");

endmodule

/* vlog.f */
+incdir+include
src/hisBuilderPkg.sv
src/sampleSequencer.sv
src/histogramRam.sv
src/peakTracker.sv
src/hisBuilderTop.sv
bench/hisBuilderTb.sv
